// File: common/memPkg.sv
package memPkg;

  // Bus widths shared by the caches, the arbiter and the memory
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;

  // Golden-ratio multiplier for the memory fill pattern
  localparam logic [dataWidth-1:0] fillMult = 32'h9E3779B1;

  // Cache controller states
  // csRelease waits for ack to fall once req has dropped
  typedef enum logic [1:0] {
    csIdle,
    csRequest,
    csRelease
  } cacheState;

  // Arbiter grant owner
  typedef enum logic [1:0] {
    gsNone,
    gsFetch,
    gsData
  } grantState;

  // Reset value of a memory word, from its word index
  function automatic logic [dataWidth-1:0] fillWord(input logic [addrWidth-1:0] wordIdx);
    fillWord = wordIdx * fillMult;
  endfunction

endpackage

// File: dcache/dataCache.sv
`timescale 1ns/100ps

module dataCache #(
  parameter int numLines = 16
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         memRead,
  input  logic                         memWrite,
  input  logic [memPkg::addrWidth-1:0] dataAddr,
  input  logic [memPkg::dataWidth-1:0] writeData,
  output logic [memPkg::dataWidth-1:0] readData,
  output logic                         dStall,
  output logic                         dReq,
  output logic [memPkg::addrWidth-1:0] dAddr,
  output logic                         dWrite,
  output logic [memPkg::dataWidth-1:0] dWData,
  input  logic                         dAck,
  input  logic [memPkg::dataWidth-1:0] busRData
);
  import memPkg::*;

  localparam int indexWidth = $clog2(numLines);
  localparam int tagWidth = addrWidth - indexWidth - 2;

  logic [numLines-1:0] validBits;
  logic [tagWidth-1:0] tagArr [numLines];
  logic [dataWidth-1:0] dataArr [numLines];

  cacheState state;

  // Pending bus access, captured when it leaves idle
  logic [addrWidth-1:0] pendAddr;
  logic [dataWidth-1:0] pendData;
  logic pendWrite;

  // One-cycle flag that a write was acknowledged
  logic wrDone;

  logic [indexWidth-1:0] lookIdx;
  logic [tagWidth-1:0] lookTag;
  logic [indexWidth-1:0] pendIdx;
  logic [tagWidth-1:0] pendTag;
  logic hit;
  logic pendHit;
  logic needBus;
  logic commit;

  assign lookIdx = dataAddr[indexWidth+1:2];
  assign lookTag = dataAddr[addrWidth-1:indexWidth+2];
  assign hit = validBits[lookIdx] && (tagArr[lookIdx] == lookTag);

  assign pendIdx = pendAddr[indexWidth+1:2];
  assign pendTag = pendAddr[addrWidth-1:indexWidth+2];
  assign pendHit = validBits[pendIdx] && (tagArr[pendIdx] == pendTag);

  // Read misses and every write go to memory
  assign needBus = (memRead && !hit) || (memWrite && !wrDone);
  assign commit = (state == csRequest) && dAck;

  assign readData = dataArr[lookIdx];
  assign dStall = needBus;

  assign dReq = (state == csRequest);
  assign dAddr = pendAddr;
  assign dWrite = pendWrite;
  assign dWData = pendData;

  // Bus controller, valid bits and write completion
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= csIdle;
      validBits <= '0;
      wrDone <= 1'b0;
    end else begin
      wrDone <= commit && pendWrite;
      case (state)
        csIdle: begin
          if (needBus) state <= csRequest;
        end
        csRequest: begin
          if (dAck) begin
            state <= csRelease;
            // No allocation on write miss
            if (!pendWrite) validBits[pendIdx] <= 1'b1;
          end
        end
        csRelease: begin
          if (!dAck) state <= csIdle;
        end
        default: state <= csIdle;
      endcase
    end
  end

  // Arrays and the captured access
  always_ff @(posedge clk) begin
    if (state == csIdle && needBus) begin
      pendAddr <= dataAddr;
      pendData <= writeData;
      pendWrite <= memWrite;
    end
    if (commit) begin
      if (!pendWrite) begin
        tagArr[pendIdx] <= pendTag;
        dataArr[pendIdx] <= busRData;
      end else if (pendHit) begin
        // Write hit keeps the line in step with memory
        dataArr[pendIdx] <= pendData;
      end
    end
  end

  rdWrExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(memRead && memWrite))
    else $error("dataCache saw memRead and memWrite together");

  dReqHeld: assert property (@(posedge clk) disable iff (!rstN)
    dReq && !dAck |=> dReq)
    else $error("dataCache dropped dReq before dAck");

endmodule

// File: icache/instrCache.sv
`timescale 1ns/100ps

module instrCache #(
  parameter int numLines = 16
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         fetchReq,
  input  logic [memPkg::addrWidth-1:0] fetchAddr,
  output logic [memPkg::dataWidth-1:0] instr,
  output logic                         iStall,
  output logic                         fReq,
  output logic [memPkg::addrWidth-1:0] fAddr,
  input  logic                         fAck,
  input  logic [memPkg::dataWidth-1:0] busRData
);
  import memPkg::*;

  // Byte address split: tag | index | 2-bit byte offset
  localparam int indexWidth = $clog2(numLines);
  localparam int tagWidth = addrWidth - indexWidth - 2;

  logic [numLines-1:0] validBits;
  logic [tagWidth-1:0] tagArr [numLines];
  logic [dataWidth-1:0] dataArr [numLines];

  cacheState state;
  logic [addrWidth-1:0] missAddr;

  logic [indexWidth-1:0] lookIdx;
  logic [tagWidth-1:0] lookTag;
  logic [indexWidth-1:0] fillIdx;
  logic [tagWidth-1:0] fillTag;
  logic hit;
  logic fillEn;

  // Lookup on the live fetch address
  assign lookIdx = fetchAddr[indexWidth+1:2];
  assign lookTag = fetchAddr[addrWidth-1:indexWidth+2];
  assign hit = validBits[lookIdx] && (tagArr[lookIdx] == lookTag);

  // Refill target comes from the address captured at the miss
  assign fillIdx = missAddr[indexWidth+1:2];
  assign fillTag = missAddr[addrWidth-1:indexWidth+2];

  // Line is written on the cycle ack is seen
  assign fillEn = (state == csRequest) && fAck;

  assign instr = dataArr[lookIdx];
  assign iStall = fetchReq && !hit;

  assign fReq = (state == csRequest);
  assign fAddr = missAddr;

  // Refill controller and valid bits
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= csIdle;
      validBits <= '0;
    end else begin
      case (state)
        csIdle: begin
          if (fetchReq && !hit) state <= csRequest;
        end
        csRequest: begin
          if (fAck) begin
            state <= csRelease;
            validBits[fillIdx] <= 1'b1;
          end
        end
        // Next request only after ack is back low
        csRelease: begin
          if (!fAck) state <= csIdle;
        end
        default: state <= csIdle;
      endcase
    end
  end

  // Tag and data arrays, plus the captured miss address
  always_ff @(posedge clk) begin
    if (state == csIdle && fetchReq && !hit) missAddr <= fetchAddr;
    if (fillEn) begin
      tagArr[fillIdx] <= fillTag;
      dataArr[fillIdx] <= busRData;
    end
  end

  // Four-phase rule: req is held until ack arrives
  fReqHeld: assert property (@(posedge clk) disable iff (!rstN)
    fReq && !fAck |=> fReq)
    else $error("instrCache dropped fReq before fAck");

endmodule

// File: run.sh
#!/bin/sh
# Build and run the memory system simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module memSystemTb -o memSystemSim

./obj_dir/memSystemSim | tee sim.log

if grep -qx "All tests passed!" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: sim/tbRef.svh
`ifndef tbRefSvh
`define tbRefSvh

// Reference model of the memory system, seen from the core
// Included inside memSystemTb so it shares the parameters

// Golden-ratio fill multiplier, same rule as the memory reset contents
localparam logic [31:0] refFillMult = 32'h9E3779B1;

logic [31:0] lfsrState;

// Main memory image, kept in step with every data write
logic [31:0] shadowMem [memWords];

// Lines the instruction cache holds, it ignores data writes
logic        icValid [numLines];
logic [31:0] icAddr [numLines];
logic [31:0] icData [numLines];

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
  logic fb;
  fb = s[31] ^ s[21] ^ s[1] ^ s[0];
  return {s[30:0], fb};
endfunction

// One LFSR step per bit taken
task automatic randBits(input int n, output logic [31:0] value);
  value = '0;
  for (int i = 0; i < n; i++) begin
    lfsrState = lfsrNext(lfsrState);
    value = {value[30:0], lfsrState[0]};
  end
endtask

task automatic initShadow();
  for (int i = 0; i < memWords; i++) begin
    shadowMem[i] = i * refFillMult;
  end
  for (int i = 0; i < numLines; i++) begin
    icValid[i] = 1'b0;
  end
endtask

// Expected word for a fetch or a data read
function automatic logic [31:0] refWord(input logic isFetch, input logic [31:0] addr);
  int line;
  int word;
  line = int'((addr >> 2) % numLines);
  word = int'((addr >> 2) % memWords);
  if (isFetch && icValid[line] && icAddr[line] == addr) return icData[line];
  return shadowMem[word];
endfunction

// A fetch miss loads the line from memory as it is now
task automatic noteFetch(input logic [31:0] addr);
  int line;
  line = int'((addr >> 2) % numLines);
  if (!(icValid[line] && icAddr[line] == addr)) begin
    icValid[line] = 1'b1;
    icAddr[line] = addr;
    icData[line] = shadowMem[int'((addr >> 2) % memWords)];
  end
endtask

task automatic shadowWrite(input logic [31:0] addr, input logic [31:0] data);
  shadowMem[int'((addr >> 2) % memWords)] = data;
endtask

`endif

// File: sim/memSystemTb.sv
`timescale 1ns/100ps

module memSystemTb;

  localparam int numLines = 16;
  localparam int memWords = 256;
  localparam int memLatency = 3;
  localparam int halfPeriod = 4;
  // Upper bound on accesses over all tests
  localparam int numAccesses = 240;
  localparam int timeoutCycles = numAccesses * (2 * memLatency + 8) + 200;

  logic clk;
  logic rstN;
  logic fetchReq;
  logic [31:0] fetchAddr;
  logic [31:0] instr;
  logic iStall;
  logic memRead;
  logic memWrite;
  logic [31:0] dataAddr;
  logic [31:0] writeData;
  logic [31:0] readData;
  logic dStall;

  int errCount = 0;
  int checkCount = 0;
  int testErrBase = 0;

  // Finished accesses waiting for the compare process
  string nameQ [$];
  logic [31:0] addrQ [$];
  logic [31:0] expQ [$];
  logic [31:0] actQ [$];
  event resultReady;

  `include "tbRef.svh"

  memSystem #(.numLines(numLines), .memWords(memWords), .memLatency(memLatency)) dut0 (
    .clk(clk), .rstN(rstN), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
    .instr(instr), .iStall(iStall), .memRead(memRead), .memWrite(memWrite),
    .dataAddr(dataAddr), .writeData(writeData), .readData(readData),
    .dStall(dStall));

  initial clk = 1'b0;
  always #(halfPeriod) clk = ~clk;

  task automatic pushResult(input string name, input logic [31:0] addr,
                            input logic [31:0] expVal, input logic [31:0] actVal);
    nameQ.push_back(name);
    addrQ.push_back(addr);
    expQ.push_back(expVal);
    actQ.push_back(actVal);
    ->resultReady;
  endtask

  // Outputs are read at the falling edge, inputs held while stalled
  task automatic fetchAccess(input string name, input logic [31:0] addr);
    logic [31:0] expVal;
    expVal = refWord(1'b1, addr);
    noteFetch(addr);
    @(posedge clk);
    fetchReq <= 1'b1;
    fetchAddr <= addr;
    do @(negedge clk); while (iStall);
    pushResult(name, addr, expVal, instr);
    @(posedge clk);
    fetchReq <= 1'b0;
  endtask

  task automatic readAccess(input string name, input logic [31:0] addr);
    logic [31:0] expVal;
    expVal = refWord(1'b0, addr);
    @(posedge clk);
    memRead <= 1'b1;
    dataAddr <= addr;
    do @(negedge clk); while (dStall);
    pushResult(name, addr, expVal, readData);
    @(posedge clk);
    memRead <= 1'b0;
  endtask

  // Write is done once dStall falls
  task automatic writeAccess(input logic [31:0] addr, input logic [31:0] data);
    shadowWrite(addr, data);
    @(posedge clk);
    memWrite <= 1'b1;
    dataAddr <= addr;
    writeData <= data;
    do @(negedge clk); while (dStall);
    @(posedge clk);
    memWrite <= 1'b0;
  endtask

  task automatic endTest(input string name);
    @(posedge clk);
    $display("test %s finished with %0d errors", name, errCount - testErrBase);
    testErrBase = errCount;
  endtask

  // Compare process
  initial begin
    string nm;
    logic [31:0] a;
    logic [31:0] e;
    logic [31:0] v;
    @(posedge rstN);
    @(negedge clk);
    if (iStall || dStall) begin
      $display("a stall output is high right after reset");
      errCount++;
    end
    forever begin
      @(resultReady);
      while (actQ.size() > 0) begin
        nm = nameQ.pop_front();
        a = addrQ.pop_front();
        e = expQ.pop_front();
        v = actQ.pop_front();
        checkCount++;
        if (v !== e) begin
          $display("mismatch test %s addr %h expected %h actual %h", nm, a, e, v);
          errCount++;
        end
      end
    end
  end

  // Watchdog
  initial begin
    repeat (timeoutCycles) @(posedge clk);
    $display("timeout, accesses did not finish within %0d cycles", timeoutCycles);
    $display("Test failures found");
    $finish;
  end

  initial begin
    logic [31:0] op;
    logic [31:0] idx;
    logic [31:0] tag;
    logic [31:0] wdata;
    logic [31:0] addr;
    rstN = 1'b0;
    fetchReq = 1'b0;
    fetchAddr = '0;
    memRead = 1'b0;
    memWrite = 1'b0;
    dataAddr = '0;
    writeData = '0;
    lfsrState = 32'd81605;
    initShadow();
    repeat (4) @(posedge clk);
    rstN <= 1'b1;

    fetchAccess("fetch miss", 32'h40);
    fetchAccess("fetch hit", 32'h40);
    endTest("fetch miss then hit");

    readAccess("read miss", 32'h80);
    readAccess("read hit", 32'h80);
    endTest("untouched data read");

    // Write hit on a loaded line, then a write miss
    readAccess("load line", 32'h100);
    writeAccess(32'h100, 32'hCAFE0001);
    readAccess("after write hit", 32'h100);
    writeAccess(32'h144, 32'hCAFE0002);
    readAccess("after write miss", 32'h144);
    endTest("write then read");

    // 0x40 is held from the first test and keeps its stale word
    writeAccess(32'h204, 32'h600D0204);
    fetchAccess("fetch new word", 32'h204);
    writeAccess(32'h40, 32'hBAD00040);
    fetchAccess("fetch stale word", 32'h40);
    endTest("instruction cache coherence");

    fork
      fetchAccess("parallel fetch", 32'h3C8);
      readAccess("parallel read", 32'h2CC);
    join
    endTest("fetch and data together");

    // Few indices and several tags to force evictions
    for (int n = 0; n < 200; n++) begin
      randBits(2, op);
      randBits(2, idx);
      randBits(3, tag);
      addr = {22'b0, 1'b0, tag[2:0], 2'b00, idx[1:0], 2'b00};
      case (op[1:0])
        2'd0: fetchAccess("random fetch", addr);
        2'd2: begin
          randBits(32, wdata);
          writeAccess(addr, wdata);
        end
        default: readAccess("random read", addr);
      endcase
    end
    endTest("random mix");

    $display("%0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: source/busArbiter.sv
`timescale 1ns/100ps

module busArbiter (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         fReq,
  input  logic [memPkg::addrWidth-1:0] fAddr,
  output logic                         fAck,
  input  logic                         dReq,
  input  logic [memPkg::addrWidth-1:0] dAddr,
  input  logic                         dWrite,
  input  logic [memPkg::dataWidth-1:0] dWData,
  output logic                         dAck,
  output logic                         mReq,
  output logic [memPkg::addrWidth-1:0] mAddr,
  output logic                         mWrite,
  output logic [memPkg::dataWidth-1:0] mWData,
  input  logic                         mAck
);
  import memPkg::*;

  grantState grant;

  // Grant register
  // data side wins a tie, release waits for the full handshake
  always_ff @(posedge clk) begin
    if (!rstN) begin
      grant <= gsNone;
    end else begin
      case (grant)
        gsNone: begin
          if (dReq) grant <= gsData;
          else if (fReq) grant <= gsFetch;
        end
        gsFetch: begin
          if (!fReq && !mAck) grant <= gsNone;
        end
        gsData: begin
          if (!dReq && !mAck) grant <= gsNone;
        end
        default: grant <= gsNone;
      endcase
    end
  end

  // Steer the granted master onto the memory side
  assign mReq = (grant == gsFetch) ? fReq : (grant == gsData) ? dReq : 1'b0;
  assign mAddr = (grant == gsData) ? dAddr : fAddr;
  assign mWrite = (grant == gsData) && dWrite;
  assign mWData = (grant == gsData) ? dWData : '0;

  // Ack only reaches its owner
  assign fAck = (grant == gsFetch) && mAck;
  assign dAck = (grant == gsData) && mAck;

  ackOneHot: assert property (@(posedge clk) disable iff (!rstN)
    !(fAck && dAck))
    else $error("busArbiter acked both masters");

  grantStable: assert property (@(posedge clk) disable iff (!rstN)
    (mReq || mAck) |=> grant == $past(grant))
    else $error("busArbiter switched grant inside a handshake");

endmodule

// File: source/memSim.sv
`timescale 1ns/100ps

module memSim #(
  parameter int memWords = 256,
  parameter int memLatency = 3
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         mReq,
  input  logic [memPkg::addrWidth-1:0] mAddr,
  input  logic                         mWrite,
  input  logic [memPkg::dataWidth-1:0] mWData,
  output logic                         mAck,
  output logic [memPkg::dataWidth-1:0] mRData
);
  import memPkg::*;

  localparam int idxWidth = $clog2(memWords);
  localparam int cntWidth = $clog2(memLatency) + 1;

  logic [dataWidth-1:0] mem [memWords];
  logic [idxWidth-1:0] wordIdx;
  logic [cntWidth-1:0] waitCnt;
  logic busy;

  // Word index, byte offset dropped
  assign wordIdx = mAddr[idxWidth+1:2];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      mAck <= 1'b0;
      busy <= 1'b0;
      waitCnt <= '0;
      for (int i = 0; i < memWords; i++) begin
        mem[i] <= fillWord(i);
      end
    end else if (busy) begin
      // Count down, then finish the access
      if (waitCnt == '0) begin
        busy <= 1'b0;
        mAck <= 1'b1;
        if (mWrite) mem[wordIdx] <= mWData;
      end else begin
        waitCnt <= waitCnt - 1'b1;
      end
    end else if (mAck) begin
      if (!mReq) mAck <= 1'b0;
    end else if (mReq) begin
      busy <= 1'b1;
      waitCnt <= cntWidth'(memLatency - 1);
    end
  end

  // Read word, held with ack
  always_ff @(posedge clk) begin
    if (busy && waitCnt == '0) mRData <= mem[wordIdx];
  end

  ackInWindow: assert property (@(posedge clk) disable iff (!rstN)
    mAck && !mReq |-> $past(mReq))
    else $error("memSim held mAck past the drop cycle");

endmodule

// File: source/memSystem.sv
`timescale 1ns/100ps

module memSystem #(
  parameter int numLines = 16,
  parameter int memWords = 256,
  parameter int memLatency = 3
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         fetchReq,
  input  logic [memPkg::addrWidth-1:0] fetchAddr,
  output logic [memPkg::dataWidth-1:0] instr,
  output logic                         iStall,
  input  logic                         memRead,
  input  logic                         memWrite,
  input  logic [memPkg::addrWidth-1:0] dataAddr,
  input  logic [memPkg::dataWidth-1:0] writeData,
  output logic [memPkg::dataWidth-1:0] readData,
  output logic                         dStall
);
  import memPkg::*;

  // Fetch side of the arbiter
  logic fReq;
  logic fAck;
  logic [addrWidth-1:0] fAddr;

  // Data side of the arbiter
  logic dReq;
  logic dAck;
  logic dWrite;
  logic [addrWidth-1:0] dAddr;
  logic [dataWidth-1:0] dWData;

  // Memory side, read data fans out to both caches
  logic mReq;
  logic mAck;
  logic mWrite;
  logic [addrWidth-1:0] mAddr;
  logic [dataWidth-1:0] mWData;
  logic [dataWidth-1:0] mRData;

  instrCache #(.numLines(numLines)) iCache0 (
    .clk(clk), .rstN(rstN), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
    .instr(instr), .iStall(iStall), .fReq(fReq), .fAddr(fAddr),
    .fAck(fAck), .busRData(mRData));

  dataCache #(.numLines(numLines)) dCache0 (
    .clk(clk), .rstN(rstN), .memRead(memRead), .memWrite(memWrite),
    .dataAddr(dataAddr), .writeData(writeData), .readData(readData),
    .dStall(dStall), .dReq(dReq), .dAddr(dAddr), .dWrite(dWrite),
    .dWData(dWData), .dAck(dAck), .busRData(mRData));

  busArbiter arb0 (
    .clk(clk), .rstN(rstN), .fReq(fReq), .fAddr(fAddr), .fAck(fAck),
    .dReq(dReq), .dAddr(dAddr), .dWrite(dWrite), .dWData(dWData), .dAck(dAck),
    .mReq(mReq), .mAddr(mAddr), .mWrite(mWrite), .mWData(mWData), .mAck(mAck));

  memSim #(.memWords(memWords), .memLatency(memLatency)) mem0 (
    .clk(clk), .rstN(rstN), .mReq(mReq), .mAddr(mAddr), .mWrite(mWrite),
    .mWData(mWData), .mAck(mAck), .mRData(mRData));

endmodule

// File: src.f
+incdir+sim
common/memPkg.sv
icache/instrCache.sv
dcache/dataCache.sv
source/busArbiter.sv
source/memSim.sv
source/memSystem.sv
sim/memSystemTb.sv
